//--- tb.f
logic/timer_bus_pkg.sv
logic/timer_core_pkg.sv
logic/timer_prescaler.sv
logic/timer_counter.sv
logic/timer_mem.sv
logic/timer_top.sv
sim/timer_tb.sv

//--- sim/timer_tb.sv
`timescale 1ns/1ns

module timer_tb
    import timer_bus_pkg::*;
    import timer_core_pkg::*;
();

    localparam int BUS_TIMEOUT = 20;    // cycles, per handshake phase
    localparam int IRQ_TIMEOUT = 200;
    localparam int PWM_TIMEOUT = 100;

    logic      clk;
    logic      rst_n;
    logic      i_enable;
    logic      i_wr_en;
    bus_addr_t i_addr;
    bus_data_t i_data;
    bus_be_t   i_be;
    logic      o_ready;
    bus_data_t o_data;
    logic      o_irq;
    logic      o_bus_err;
    logic      o_pwm;

    integer    seed;
    int        value_errors;
    int        other_errors;
    bus_data_t exp_reg [0:15];   // last value written, by word address

    timer_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_enable  (i_enable),
        .i_wr_en   (i_wr_en),
        .i_addr    (i_addr),
        .i_data    (i_data),
        .i_be      (i_be),
        .o_ready   (o_ready),
        .o_data    (o_data),
        .o_irq     (o_irq),
        .o_bus_err (o_bus_err),
        .o_pwm     (o_pwm)
    );

    always #50 clk = ~clk;

    task automatic check_data(input string name, input bus_data_t got, input bus_data_t exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
            value_errors++;
        end
    endtask

    // word address to slot in exp_reg
    function automatic int reg_slot(input bus_addr_t addr);
        return int'(addr[5:2]);
    endfunction

    // implemented bits of each writable register
    function automatic bus_data_t reg_mask(input bus_addr_t addr);
        if (addr == REG_INT_ENABLE)
        begin
            return 32'h3;
        end
        else if (addr == REG_ENABLE)
        begin
            return 32'h1;
        end
        return 32'hFF;   // byte registers
    endfunction

    // starts and ends 1 ns after a rising edge
    task automatic bus_cycle(input logic wr, input bus_addr_t addr, input bus_data_t wdata,
                             input bus_be_t be, output bus_data_t rdata, output logic err);
        int waited;
        waited   = 0;
        i_enable = 1'b1;
        i_wr_en  = wr;
        i_addr   = addr;
        i_data   = wdata;
        i_be     = be;
        @(posedge clk);
        #1;
        while (!o_ready && waited < BUS_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!o_ready)
        begin
            $display("no ready from the bus for address %h", addr);
            other_errors++;
        end
        rdata    = o_data;
        err      = o_bus_err;
        i_enable = 1'b0;   // release, the bank drops ready on the next edge
        i_wr_en  = 1'b0;
        waited   = 0;
        @(posedge clk);
        #1;
        while (o_ready && waited < BUS_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (o_ready)
        begin
            $display("ready stayed high after release for address %h", addr);
            other_errors++;
        end
    endtask

    task automatic bus_write(input bus_addr_t addr, input bus_data_t data);
        bus_data_t rdata;
        logic      err;
        bus_cycle(1'b1, addr, data, 4'hF, rdata, err);
        check_bit("o_bus_err", err, 1'b0);
    endtask

    task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
        logic err;
        bus_cycle(1'b0, addr, '0, 4'hF, data, err);
        check_bit("o_bus_err", err, 1'b0);
    endtask

    task automatic wait_pwm(input logic level);
        int waited;
        waited = 0;
        while (o_pwm !== level && waited < PWM_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (o_pwm !== level)
        begin
            $display("pwm output did not reach %b within %0d cycles", level, PWM_TIMEOUT);
            other_errors++;
        end
    endtask

    task automatic count_pwm_high(input int cycles, output int high_cycles);
        high_cycles = 0;
        repeat (cycles)
        begin
            if (o_pwm)
            begin
                high_cycles++;
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic test_register_rw();
        bus_addr_t regs [0:6];
        bus_data_t wdata;
        bus_data_t rdata;
        regs[0] = REG_TOP_L;
        regs[1] = REG_TOP_H;
        regs[2] = REG_CMP_L;
        regs[3] = REG_CMP_H;
        regs[4] = REG_PRESCALE;
        regs[5] = REG_INT_ENABLE;
        regs[6] = REG_ENABLE;
        for (int i = 0; i < 7; i++)
        begin
            wdata = $random(seed);   // upper bits must be dropped by the bank
            exp_reg[reg_slot(regs[i])] = wdata & reg_mask(regs[i]);
            bus_write(regs[i], wdata);
        end
        for (int i = 0; i < 7; i++)
        begin
            bus_read(regs[i], rdata);
            check_data($sformatf("o_data @%h", regs[i]), rdata, exp_reg[reg_slot(regs[i])]);
        end
        bus_write(REG_ENABLE, 32'h0);
        exp_reg[reg_slot(REG_ENABLE)] = '0;
    endtask

    task automatic test_bus_errors();
        bus_data_t rdata;
        logic      err;
        bus_cycle(1'b1, 32'h28, 32'h5A, 4'hF, rdata, err);
        check_bit("o_bus_err (write 0x28)", err, 1'b1);
        bus_cycle(1'b0, 32'h28, '0, 4'hF, rdata, err);
        check_bit("o_bus_err (read 0x28)", err, 1'b1);
        // lane 0 off, value differs from the stored one so a bad write shows
        bus_cycle(1'b1, REG_TOP_L, ~exp_reg[reg_slot(REG_TOP_L)] & 32'hFF, 4'hE, rdata, err);
        check_bit("o_bus_err (be 0xE)", err, 1'b1);
        bus_read(REG_TOP_L, rdata);
        check_data("o_data TOP_L", rdata, exp_reg[reg_slot(REG_TOP_L)]);
    endtask

    task automatic test_top_irq();
        bus_data_t rdata;
        int        waited;
        bus_write(REG_ENABLE, 32'h0);
        bus_write(REG_INT_ENABLE, 32'h0);
        bus_write(REG_TOP_L, 32'h05);
        bus_write(REG_TOP_H, 32'h00);
        bus_write(REG_PRESCALE, 32'h00);
        bus_write(REG_INT_PENDING, 32'h3);   // drop leftovers of earlier tests
        bus_write(REG_INT_ENABLE, 32'h1 << INT_TOP);
        check_bit("o_irq", o_irq, 1'b0);
        bus_write(REG_ENABLE, 32'h1);
        waited = 0;
        while (!o_irq && waited < IRQ_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (!o_irq)
        begin
            $display("TOP interrupt did not arrive within %0d cycles", IRQ_TIMEOUT);
            other_errors++;
        end
        bus_write(REG_ENABLE, 32'h0);
        bus_read(REG_INT_PENDING, rdata);
        check_data("o_data INT_PENDING bit 0", rdata & 32'h1, 32'h1);
        bus_write(REG_INT_PENDING, 32'h1);
        bus_read(REG_INT_PENDING, rdata);
        check_data("o_data INT_PENDING bit 0", rdata & 32'h1, 32'h0);
        check_bit("o_irq", o_irq, 1'b0);
    endtask

    task automatic test_pwm();
        int high_cycles;
        bus_write(REG_ENABLE, 32'h0);
        bus_write(REG_TOP_L, 32'h09);
        bus_write(REG_TOP_H, 32'h00);
        bus_write(REG_CMP_L, 32'h04);
        bus_write(REG_CMP_H, 32'h00);
        bus_write(REG_PRESCALE, 32'h01);   // count ticks every second cycle
        bus_write(REG_ENABLE, 32'h1);
        wait_pwm(1'b0);
        wait_pwm(1'b1);   // first rising edge starts a full period
        count_pwm_high(40, high_cycles);
        check_data("o_pwm high cycles", high_cycles, 32'd16);
        bus_write(REG_CMP_L, 32'h00);
        count_pwm_high(40, high_cycles);
        check_data("o_pwm high cycles (CMP=0)", high_cycles, 32'd0);
        bus_write(REG_ENABLE, 32'h0);
    endtask

    task automatic test_counter_snapshot();
        bus_data_t lo;
        bus_data_t hi;
        cnt_t      first;
        cnt_t      second;
        int        run_cycles;
        bus_write(REG_ENABLE, 32'h0);
        bus_write(REG_TOP_L, 32'h2C);   // TOP = 300, high byte gets used
        bus_write(REG_TOP_H, 32'h01);
        bus_write(REG_PRESCALE, 32'h00);
        bus_write(REG_ENABLE, 32'h1);
        run_cycles = 20 + ($random(seed) & 511);
        repeat (run_cycles)
        begin
            @(posedge clk);
            #1;
        end
        bus_write(REG_ENABLE, 32'h0);   // freeze
        bus_read(REG_COUNTER_L, lo);
        bus_read(REG_COUNTER_H, hi);
        first = {hi[7:0], lo[7:0]};
        bus_read(REG_COUNTER_L, lo);
        bus_read(REG_COUNTER_H, hi);
        second = {hi[7:0], lo[7:0]};
        check_data("counter read pair", bus_data_t'(second), bus_data_t'(first));
        if (first > 16'h012C)
        begin
            $display("frozen counter value %h is above TOP 012c", first);
            other_errors++;
        end
    endtask

    initial
    begin
        seed         = 52;
        value_errors = 0;
        other_errors = 0;
        clk          = 1'b0;
        rst_n        = 1'b0;
        i_enable     = 1'b0;
        i_wr_en      = 1'b0;
        i_addr       = '0;
        i_data       = '0;
        i_be         = '0;
        for (int i = 0; i < 16; i++)
        begin
            exp_reg[i] = '0;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_bit("o_ready", o_ready, 1'b0);
        check_bit("o_bus_err", o_bus_err, 1'b0);
        check_bit("o_irq", o_irq, 1'b0);
        check_bit("o_pwm", o_pwm, 1'b0);

        test_register_rw();
        test_bus_errors();
        test_top_irq();
        test_pwm();
        test_counter_snapshot();

        $display("checks done, %0d value errors, %0d other errors", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
        begin
            $display("TESTBENCH PASSED");
        end
        else
        begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- logic/timer_top.sv
`timescale 1ns/1ns

module timer_top
    import timer_bus_pkg::*;
    import timer_core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      i_enable,
    input  logic      i_wr_en,
    input  bus_addr_t i_addr,
    input  bus_data_t i_data,
    input  bus_be_t   i_be,
    output logic      o_ready,
    output bus_data_t o_data,
    output logic      o_irq,
    output logic      o_bus_err,
    output logic      o_pwm
);

    logic   go;
    logic   relatch;
    logic   tick;
    presc_t prescale;
    cnt_t   top;
    cnt_t   cmp;
    cnt_t   count;
    logic   top_match;
    logic   cmp_match;

    timer_mem u_mem (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_enable    (i_enable),
        .i_wr_en     (i_wr_en),
        .i_addr      (i_addr),
        .i_data      (i_data),
        .i_be        (i_be),
        .o_ready     (o_ready),
        .o_data      (o_data),
        .o_irq       (o_irq),
        .o_bus_err   (o_bus_err),
        .o_go        (go),
        .o_relatch   (relatch),
        .o_prescale  (prescale),
        .o_top       (top),
        .o_cmp       (cmp),
        .i_count     (count),
        .i_top_match (top_match),
        .i_cmp_match (cmp_match)
    );

    timer_prescaler u_presc (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_go       (go),
        .i_relatch  (relatch),
        .i_prescale (prescale),
        .o_tick     (tick)
    );

    timer_counter u_cnt (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_tick      (tick),
        .i_go        (go),
        .i_relatch   (relatch),
        .i_top       (top),
        .i_cmp       (cmp),
        .o_count     (count),
        .o_top_match (top_match),
        .o_cmp_match (cmp_match),
        .o_pwm       (o_pwm)
    );

endmodule

//--- logic/timer_mem.sv
`timescale 1ns/1ns

module timer_mem
    import timer_bus_pkg::*;
    import timer_core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      i_enable,     // held high for one command, low in between
    input  logic      i_wr_en,      // 1 write, 0 read
    input  bus_addr_t i_addr,
    input  bus_data_t i_data,
    input  bus_be_t   i_be,         // only lane 0 is used, it must be set
    output logic      o_ready,
    output bus_data_t o_data,
    output logic      o_irq,
    output logic      o_bus_err,
    output logic      o_go,
    output logic      o_relatch,
    output presc_t    o_prescale,
    output cnt_t      o_top,
    output cnt_t      o_cmp,
    input  cnt_t      i_count,
    input  logic      i_top_match,
    input  logic      i_cmp_match
);

    typedef enum logic {ST_ISSUE, ST_RETIRE} state_t;

    state_t   state;
    logic     addr_err;       // unmapped address seen in the issue cycle
    logic     issue;
    int_vec_t int_en;
    int_vec_t int_pend;
    int_vec_t match_now;
    int_vec_t match_q;
    int_vec_t match_rise;
    int_vec_t pend_clr;
    cnt_t     cnt_snap;       // counter copy for the COUNTER_H read

    logic [BYTE_W-1:0] wr_byte;

    assign wr_byte = i_data[BYTE_W-1:0];
    assign issue   = i_enable && !o_ready && (state == ST_ISSUE) && i_be[0];

    assign match_now[INT_TOP] = i_top_match;
    assign match_now[INT_CMP] = i_cmp_match;
    assign match_rise         = match_now & ~match_q;

    assign pend_clr = (issue && i_wr_en && (i_addr == REG_INT_PENDING)) ?
                      int_vec_t'(i_data[INT_W-1:0]) : '0;

    assign o_irq = |(int_en & int_pend);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            match_q  <= '1;   // a match already present at reset is not an edge
            int_pend <= '0;
        end
        else
        begin
            match_q  <= match_now;
            int_pend <= (int_pend & ~pend_clr) | match_rise;   // new edge wins over clear
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state      <= ST_ISSUE;
            o_ready    <= 1'b0;
            o_bus_err  <= 1'b0;
            addr_err   <= 1'b0;
            o_data     <= '0;
            o_go       <= 1'b0;
            o_relatch  <= 1'b0;
            o_prescale <= '0;
            o_top      <= '0;
            o_cmp      <= '0;
            int_en     <= '0;
            cnt_snap   <= '0;
        end
        else
        begin
            o_relatch <= 1'b0;   // single cycle pulse
            if (!i_enable)
            begin
                // master released, get ready for the next command
                o_ready   <= 1'b0;
                o_bus_err <= 1'b0;
                addr_err  <= 1'b0;
                state     <= ST_ISSUE;
            end
            else if (!o_ready)
            begin
                if (!i_be[0])
                begin
                    o_ready   <= 1'b1;   // reject at once, nothing written
                    o_bus_err <= 1'b1;
                end
                else if (state == ST_RETIRE)
                begin
                    o_ready   <= 1'b1;
                    o_bus_err <= addr_err;
                end
                else
                begin
                    state <= ST_RETIRE;
                    if (i_wr_en)
                    begin
                        case (i_addr)
                            REG_TOP_L:
                            begin
                                o_top[BYTE_W-1:0] <= wr_byte;
                                o_relatch         <= 1'b1;
                            end
                            REG_TOP_H:
                            begin
                                o_top[CNT_W-1:BYTE_W] <= wr_byte;
                                o_relatch             <= 1'b1;
                            end
                            REG_CMP_L:
                            begin
                                o_cmp[BYTE_W-1:0] <= wr_byte;
                                o_relatch         <= 1'b1;
                            end
                            REG_CMP_H:
                            begin
                                o_cmp[CNT_W-1:BYTE_W] <= wr_byte;
                                o_relatch             <= 1'b1;
                            end
                            REG_PRESCALE:
                            begin
                                o_prescale <= wr_byte;
                                o_relatch  <= 1'b1;
                            end
                            REG_INT_ENABLE:  int_en <= i_data[INT_W-1:0];
                            REG_ENABLE:      o_go   <= i_data[FLD_GO];
                            REG_INT_PENDING, REG_COUNTER_L, REG_COUNTER_H:
                            begin
                                // pending clear is done above, counter is read only
                            end
                            default:         addr_err <= 1'b1;
                        endcase
                    end
                    else
                    begin
                        case (i_addr)
                            REG_TOP_L:       o_data <= bus_data_t'(o_top[BYTE_W-1:0]);
                            REG_TOP_H:       o_data <= bus_data_t'(o_top[CNT_W-1:BYTE_W]);
                            REG_CMP_L:       o_data <= bus_data_t'(o_cmp[BYTE_W-1:0]);
                            REG_CMP_H:       o_data <= bus_data_t'(o_cmp[CNT_W-1:BYTE_W]);
                            REG_PRESCALE:    o_data <= bus_data_t'(o_prescale);
                            REG_INT_ENABLE:  o_data <= bus_data_t'(int_en);
                            REG_INT_PENDING: o_data <= bus_data_t'(int_pend);
                            REG_ENABLE:      o_data <= bus_data_t'(o_go);
                            REG_COUNTER_L:
                            begin
                                cnt_snap <= i_count;   // hold the rest for the high read
                                o_data   <= bus_data_t'(i_count[BYTE_W-1:0]);
                            end
                            REG_COUNTER_H:   o_data <= bus_data_t'(cnt_snap[CNT_W-1:BYTE_W]);
                            default:
                            begin
                                o_data   <= '0;
                                addr_err <= 1'b1;
                            end
                        endcase
                    end
                end
            end
        end
    end

    // an error is only reported together with the acknowledge
    a_err_with_ready : assert property (
        @(posedge clk) disable iff (!rst_n)
        o_bus_err |-> o_ready
    );

endmodule

//--- logic/timer_counter.sv
`timescale 1ns/1ns

module timer_counter
    import timer_core_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic i_tick,
    input  logic i_go,
    input  logic i_relatch,
    input  cnt_t i_top,
    input  cnt_t i_cmp,
    output cnt_t o_count,
    output logic o_top_match,
    output logic o_cmp_match,
    output logic o_pwm
);

    cnt_t cnt_q;
    cnt_t top_sh;   // shadow copies, only change on relatch
    cnt_t cmp_sh;

    logic at_top;

    assign at_top = (cnt_q == top_sh);

    // shadow registers so that a half-written 16-bit value never reaches the compare
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            top_sh <= '0;
            cmp_sh <= '0;
        end
        else if (i_relatch)
        begin
            top_sh <= i_top;
            cmp_sh <= i_cmp;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cnt_q <= '0;
        end
        else if (i_relatch)
        begin
            cnt_q <= '0;   // restart period with the new settings
        end
        else if (i_go && i_tick)
        begin
            if (at_top)
            begin
                cnt_q <= '0;   // wrap instead of passing TOP
            end
            else
            begin
                cnt_q <= cnt_q + 1'b1;
            end
        end
    end

    assign o_count     = cnt_q;
    assign o_top_match = at_top;
    assign o_cmp_match = (cnt_q == cmp_sh);

    // high for counts 0 .. CMP-1, so CMP of zero keeps the output low
    assign o_pwm = i_go && (cnt_q < cmp_sh);

    a_relatch_clears_count : assert property (
        @(posedge clk) disable iff (!rst_n)
        i_relatch |=> (o_count == '0)
    );

endmodule

//--- logic/timer_prescaler.sv
`timescale 1ns/1ns

module timer_prescaler
    import timer_core_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  logic   i_go,
    input  logic   i_relatch,
    input  presc_t i_prescale,
    output logic   o_tick
);

    presc_t cnt_q;   // cycles left until the next tick

    // tick on the zero state, a relatch starts a fresh period
    assign o_tick = i_go && !i_relatch && (cnt_q == '0);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cnt_q <= '0;
        end
        else if (i_relatch)
        begin
            cnt_q <= i_prescale;   // new divider takes effect from here
        end
        else if (i_go)
        begin
            if (cnt_q == '0)
            begin
                cnt_q <= i_prescale;   // reload, period is prescale + 1
            end
            else
            begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
        // with go low the count simply holds
    end

    // a tick reloads the divider, so ticks come back to back only for prescale zero
    a_tick_spacing : assert property (
        @(posedge clk) disable iff (!rst_n)
        o_tick && (i_prescale != '0) |=> !o_tick
    );

endmodule

//--- logic/timer_core_pkg.sv
package timer_core_pkg;

    localparam int CNT_W   = 16;   // main counter, TOP and CMP
    localparam int PRESC_W = 8;    // clock divider setting

    // interrupt sources, bit positions in enable and pending
    localparam int INT_W   = 2;
    localparam int INT_TOP = 0;    // counter reached TOP
    localparam int INT_CMP = 1;    // counter reached CMP

    typedef logic [CNT_W-1:0]   cnt_t;
    typedef logic [PRESC_W-1:0] presc_t;
    typedef logic [INT_W-1:0]   int_vec_t;

endpackage

//--- logic/timer_bus_pkg.sv
package timer_bus_pkg;

    localparam int BUS_ADDR_W = 32;
    localparam int BUS_DATA_W = 32;
    localparam int BUS_BE_W   = BUS_DATA_W / 8;   // one enable per byte lane

    localparam int BYTE_W = 8;                    // registers live in byte lane 0 only

    typedef logic [BUS_ADDR_W-1:0] bus_addr_t;
    typedef logic [BUS_DATA_W-1:0] bus_data_t;
    typedef logic [BUS_BE_W-1:0]   bus_be_t;

    // register map, one byte register per word address
    localparam bus_addr_t REG_TOP_L       = 32'h0000_0000;   // TOP bits 7:0
    localparam bus_addr_t REG_TOP_H       = 32'h0000_0004;   // TOP bits 15:8
    localparam bus_addr_t REG_CMP_L       = 32'h0000_0008;   // compare bits 7:0
    localparam bus_addr_t REG_CMP_H       = 32'h0000_000C;   // compare bits 15:8
    localparam bus_addr_t REG_PRESCALE    = 32'h0000_0010;   // tick divider minus one
    localparam bus_addr_t REG_INT_ENABLE  = 32'h0000_0014;
    localparam bus_addr_t REG_INT_PENDING = 32'h0000_0018;   // write one to clear
    localparam bus_addr_t REG_ENABLE      = 32'h0000_001C;
    localparam bus_addr_t REG_COUNTER_L   = 32'h0000_0020;   // read first, takes snapshot
    localparam bus_addr_t REG_COUNTER_H   = 32'h0000_0024;   // returns snapshot high byte

    // field positions inside the ENABLE register
    localparam int FLD_GO = 0;

endpackage
